//--- verilog/cd_pkg.sv
// shared encodings for the controller; a page holds 256 bytes but a frame carries at most 255
package cd_pkg;

    // host register map
    typedef enum logic [4:0] {
        VERSION  = 5'h00,
        SETTING  = 5'h02,
        IDLE_LEN = 5'h04,
        DIV_L    = 5'h0c,
        DIV_H    = 5'h0d,
        INT_MASK = 5'h11,
        INT_FLAG = 5'h12,
        RX_LEN   = 5'h13,
        RX       = 5'h14,
        TX       = 5'h15,
        RX_CTRL  = 5'h16,
        TX_CTRL  = 5'h17
    } csr_addr_e;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP,
        RX_GAP
    } rx_state_e;

    localparam int PAGE_SIZE = 256;
    localparam logic [7:0] IDLE_LEN_RST = 8'd10;

    // bit positions in INT_FLAG, the upper three bits read as zero
    localparam int INT_BUS_IDLE   = 0;
    localparam int INT_RX_PENDING = 1;
    localparam int INT_RX_ERROR   = 2;
    localparam int INT_RX_LOST    = 3;
    localparam int INT_TX_DONE    = 4;

endpackage

//--- verilog/cd_tx_if.sv
// transmit side link; the frame length is whatever wr_addr holds while send is high
`timescale 1ns/1ps

interface cd_tx_if;

    logic        wr_en;
    logic [7:0]  wr_addr;
    logic [7:0]  wr_data;
    logic        send;
    logic [15:0] div;
    logic        tx_invert;
    logic        pending;

    modport csr (
        output wr_en, wr_addr, wr_data, send, div, tx_invert,
        input  pending
    );

    modport tx (
        input  wr_en, wr_addr, wr_data, send, div, tx_invert,
        output pending
    );

endinterface

//--- verilog/cd_rx_if.sv
// receive side link; error and lost are single-cycle pulses that the register block holds
`timescale 1ns/1ps

interface cd_rx_if;

    logic [7:0]  rd_addr;
    logic        rd_done;
    logic        clean;
    logic [15:0] div;
    logic [7:0]  idle_len;
    logic        rx_invert;
    logic [7:0]  rd_byte;
    logic [7:0]  rd_len;
    logic        pending;
    logic        error;
    logic        lost;
    logic        bus_idle;

    modport csr (
        output rd_addr, rd_done, clean, div, idle_len, rx_invert,
        input  rd_byte, rd_len, pending, error, lost, bus_idle
    );

    modport rx (
        input  rd_addr, rd_done, clean, div, idle_len, rx_invert,
        output rd_byte, rd_len, pending, error, lost, bus_idle
    );

endinterface

//--- verilog/cd_csr.sv
// host register block; read and write strobes must not overlap and DIV_RESET must be at least 4
`timescale 1ns/1ps

module cd_csr #(
    parameter logic [7:0]  VERSION   = 8'h0f,
    parameter logic [15:0] DIV_RESET = 16'd8
) (
    input  logic        clk,
    input  logic        reset_n,
    input  logic [4:0]  csr_address,
    input  logic        csr_read,
    input  logic        csr_write,
    input  logic [7:0]  csr_writedata,
    output logic [7:0]  csr_readdata,
    output logic        irq,
    cd_tx_if.csr        tx,
    cd_rx_if.csr        rx
);

    logic        rx_invert;
    logic        tx_invert;
    logic [7:0]  idle_len;
    logic [15:0] div;
    logic [7:0]  div_bkup;
    logic [7:0]  int_mask;
    logic [7:0]  int_flag;
    logic        rx_error_flag;
    logic        rx_lost_flag;
    logic [7:0]  rx_rd_addr;
    logic [7:0]  tx_wr_addr;
    logic        send_arm;

    always_comb begin
        int_flag = 8'd0;
        int_flag[cd_pkg::INT_BUS_IDLE]   = rx.bus_idle;
        int_flag[cd_pkg::INT_RX_PENDING] = rx.pending;
        int_flag[cd_pkg::INT_RX_ERROR]   = rx_error_flag;
        int_flag[cd_pkg::INT_RX_LOST]    = rx_lost_flag;
        int_flag[cd_pkg::INT_TX_DONE]    = ~tx.pending;
    end

    assign irq = |(int_flag & int_mask);

    assign tx.wr_en     = csr_write && (csr_address == cd_pkg::TX);
    assign tx.wr_addr   = tx_wr_addr;
    assign tx.wr_data   = csr_writedata;
    assign tx.div       = div;
    assign tx.tx_invert = tx_invert;

    assign rx.rd_addr   = rx_rd_addr;
    assign rx.div       = div;
    assign rx.idle_len  = idle_len;
    assign rx.rx_invert = rx_invert;

    always_comb begin
        case (csr_address)
            cd_pkg::VERSION:  csr_readdata = VERSION;
            cd_pkg::SETTING:  csr_readdata = {1'b0, rx_invert, 4'd0, tx_invert, 1'b0};
            cd_pkg::IDLE_LEN: csr_readdata = idle_len;
            cd_pkg::DIV_L:    csr_readdata = div[7:0];
            cd_pkg::DIV_H:    csr_readdata = div[15:8];
            cd_pkg::INT_MASK: csr_readdata = int_mask;
            cd_pkg::INT_FLAG: csr_readdata = int_flag;
            cd_pkg::RX_LEN:   csr_readdata = rx.rd_len;
            cd_pkg::RX:       csr_readdata = rx.rd_byte;
            default:          csr_readdata = 8'd0;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rx_invert     <= 1'b0;
            tx_invert     <= 1'b0;
            idle_len      <= cd_pkg::IDLE_LEN_RST;
            div           <= DIV_RESET;
            div_bkup      <= 8'd0;
            int_mask      <= 8'd0;
            rx_error_flag <= 1'b0;
            rx_lost_flag  <= 1'b0;
            rx_rd_addr    <= 8'd0;
            tx_wr_addr    <= 8'd0;
            send_arm      <= 1'b0;
            tx.send       <= 1'b0;
            rx.rd_done    <= 1'b0;
            rx.clean      <= 1'b0;
        end else begin
            send_arm   <= 1'b0;
            tx.send    <= send_arm;
            rx.rd_done <= 1'b0;
            rx.clean   <= 1'b0;

            // the transmitter takes the length on the send cycle, so the address clears after it
            if (tx.send)
                tx_wr_addr <= 8'd0;

            if (csr_read) begin
                if (csr_address == cd_pkg::INT_FLAG) begin
                    rx_error_flag <= 1'b0;
                    rx_lost_flag  <= 1'b0;
                end else if (csr_address == cd_pkg::RX) begin
                    rx_rd_addr <= rx_rd_addr + 8'd1;
                end
            end

            if (rx.error)
                rx_error_flag <= 1'b1;
            if (rx.lost)
                rx_lost_flag <= 1'b1;

            if (csr_write) begin
                case (csr_address)
                    cd_pkg::SETTING: begin
                        rx_invert <= csr_writedata[6];
                        tx_invert <= csr_writedata[1];
                    end
                    cd_pkg::IDLE_LEN: idle_len <= csr_writedata;
                    cd_pkg::DIV_L:    div <= {div_bkup, csr_writedata};
                    cd_pkg::DIV_H:    div_bkup <= csr_writedata;
                    cd_pkg::INT_MASK: int_mask <= csr_writedata;
                    cd_pkg::TX:       tx_wr_addr <= tx_wr_addr + 8'd1;
                    cd_pkg::RX_CTRL: begin
                        rx_rd_addr <= 8'd0;
                        rx.rd_done <= csr_writedata[1];
                        rx.clean   <= csr_writedata[4];
                    end
                    cd_pkg::TX_CTRL: begin
                        if (csr_writedata[1])
                            send_arm <= 1'b1;
                        else
                            tx_wr_addr <= 8'd0;
                    end
                    default: ;
                endcase
            end
        end
    end

    a_no_read_write: assert property (@(posedge clk) disable iff (!reset_n)
        !(csr_read && csr_write))
        else $error("csr_read and csr_write high in the same cycle");

endmodule

//--- verilog/cd_tx.sv
// transmit page and serializer; a send that arrives while a frame is on the line is dropped
`timescale 1ns/1ps

module cd_tx (
    input  logic clk,
    input  logic reset_n,
    cd_tx_if.tx  bus,
    output logic tx_line
);

    logic [7:0]  mem [cd_pkg::PAGE_SIZE];
    logic [7:0]  tx_len;
    logic [7:0]  idx;
    logic [7:0]  shift;
    logic [2:0]  bit_cnt;
    logic [15:0] cnt;
    logic        tick;
    logic        line_bit;
    cd_pkg::tx_state_e state;

    always_ff @(posedge clk) begin
        if (bus.wr_en)
            mem[bus.wr_addr] <= bus.wr_data;
    end

    assign tick        = cnt == bus.div - 16'd1;
    assign bus.pending = state != cd_pkg::TX_IDLE;

    always_comb begin
        case (state)
            cd_pkg::TX_START: line_bit = idx == tx_len;
            cd_pkg::TX_DATA:  line_bit = shift[0];
            default:          line_bit = 1'b1;
        endcase
    end

    assign tx_line = line_bit ^ bus.tx_invert;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= cd_pkg::TX_IDLE;
            tx_len  <= 8'd0;
            idx     <= 8'd0;
            bit_cnt <= 3'd0;
            cnt     <= 16'd0;
        end else begin
            case (state)
                cd_pkg::TX_IDLE: begin
                    if (bus.send) begin
                        tx_len <= bus.wr_addr;
                        idx    <= 8'd0;
                        cnt    <= 16'd0;
                        state  <= cd_pkg::TX_START;
                    end
                end
                cd_pkg::TX_START: begin
                    // all bytes sent, this cycle is the tail of pending
                    if (idx == tx_len) begin
                        state <= cd_pkg::TX_IDLE;
                    end else if (tick) begin
                        cnt     <= 16'd0;
                        bit_cnt <= 3'd0;
                        shift   <= mem[idx];
                        state   <= cd_pkg::TX_DATA;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                cd_pkg::TX_DATA: begin
                    if (tick) begin
                        cnt     <= 16'd0;
                        shift   <= shift >> 1;
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7)
                            state <= cd_pkg::TX_STOP;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                default: begin
                    if (tick) begin
                        cnt   <= 16'd0;
                        idx   <= idx + 8'd1;
                        state <= cd_pkg::TX_START;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
            endcase
        end
    end

    a_send_idle: assert property (@(posedge clk) disable iff (!reset_n)
        bus.send |-> !bus.pending)
        else $error("send while a frame is still being transmitted");

endmodule

//--- verilog/cd_rx.sv
// receive deserializer and page; the host must release a pending page or new frames are dropped
`timescale 1ns/1ps

module cd_rx (
    input  logic clk,
    input  logic reset_n,
    cd_rx_if.rx  bus,
    input  logic rx_line
);

    logic [7:0]  mem [cd_pkg::PAGE_SIZE];
    logic        rx_meta;
    logic        rx_sync;
    logic        line;
    logic        line_d;
    logic [15:0] cnt;
    logic [2:0]  bit_cnt;
    logic [7:0]  shift;
    logic [7:0]  byte_cnt;
    logic [7:0]  gap_bits;
    logic [7:0]  wr_ptr;
    logic        frame_open;
    logic        frame_drop;
    logic        start_edge;
    logic        tick_half;
    logic        tick_full;
    logic        store_en;
    cd_pkg::rx_state_e state;

    assign line       = rx_sync ^ bus.rx_invert;
    assign start_edge = line_d & ~line;
    assign tick_half  = cnt == {1'b0, bus.div[15:1]} - 16'd1;
    assign tick_full  = cnt == bus.div - 16'd1;
    assign store_en   = (state == cd_pkg::RX_STOP) && tick_full && line
                        && !bus.pending && !frame_drop;
    // the first byte of a frame starts over at address 0
    assign wr_ptr     = frame_open ? byte_cnt : 8'd0;

    always_ff @(posedge clk) begin
        if (store_en)
            mem[wr_ptr] <= shift;
    end

    assign bus.rd_byte  = mem[bus.rd_addr];
    assign bus.rd_len   = byte_cnt;
    assign bus.bus_idle = state == cd_pkg::RX_IDLE;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rx_meta     <= 1'b1;
            rx_sync     <= 1'b1;
            line_d      <= 1'b1;
            state       <= cd_pkg::RX_IDLE;
            cnt         <= 16'd0;
            bit_cnt     <= 3'd0;
            gap_bits    <= 8'd0;
            byte_cnt    <= 8'd0;
            frame_open  <= 1'b0;
            frame_drop  <= 1'b0;
            bus.pending <= 1'b0;
            bus.error   <= 1'b0;
            bus.lost    <= 1'b0;
        end else begin
            rx_meta   <= rx_line;
            rx_sync   <= rx_meta;
            line_d    <= line;
            bus.error <= 1'b0;
            bus.lost  <= 1'b0;
            case (state)
                cd_pkg::RX_IDLE: begin
                    if (start_edge) begin
                        cnt   <= 16'd0;
                        state <= cd_pkg::RX_START;
                    end
                end
                cd_pkg::RX_START: begin
                    if (tick_half) begin
                        cnt      <= 16'd0;
                        bit_cnt  <= 3'd0;
                        gap_bits <= 8'd0;
                        state    <= line ? cd_pkg::RX_GAP : cd_pkg::RX_DATA;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                cd_pkg::RX_DATA: begin
                    if (tick_full) begin
                        cnt     <= 16'd0;
                        shift   <= {line, shift[7:1]};
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7)
                            state <= cd_pkg::RX_STOP;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                cd_pkg::RX_STOP: begin
                    if (tick_full) begin
                        cnt      <= 16'd0;
                        gap_bits <= 8'd0;
                        state    <= cd_pkg::RX_GAP;
                        if (!line) begin
                            bus.error <= 1'b1;
                        end else if (store_en) begin
                            byte_cnt   <= wr_ptr + 8'd1;
                            frame_open <= 1'b1;
                        end else if (!frame_drop) begin
                            frame_drop <= 1'b1;
                            bus.lost   <= 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                default: begin
                    if (start_edge) begin
                        cnt   <= 16'd0;
                        state <= cd_pkg::RX_START;
                    end else if (!line) begin
                        cnt      <= 16'd0;
                        gap_bits <= 8'd0;
                    end else if (tick_full) begin
                        cnt      <= 16'd0;
                        gap_bits <= gap_bits + 8'd1;
                        if (gap_bits + 8'd1 >= bus.idle_len) begin
                            state      <= cd_pkg::RX_IDLE;
                            frame_open <= 1'b0;
                            frame_drop <= 1'b0;
                            if (frame_open)
                                bus.pending <= 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
            endcase

            if (bus.rd_done)
                bus.pending <= 1'b0;
            if (bus.clean) begin
                bus.pending <= 1'b0;
                byte_cnt    <= 8'd0;
                frame_open  <= 1'b0;
            end
        end
    end

    a_len_no_wrap: assert property (@(posedge clk) disable iff (!reset_n)
        store_en |=> byte_cnt != 8'd0)
        else $error("receive byte count wrapped past the page size");

endmodule

//--- verilog/cd_ctrl.sv
// controller top; the serial lines are plain wires and any inversion is set through SETTING
`timescale 1ns/1ps

module cd_ctrl #(
    parameter logic [7:0]  VERSION   = 8'h0f,
    parameter logic [15:0] DIV_RESET = 16'd8
) (
    input  logic       clk,
    input  logic       reset_n,
    input  logic [4:0] csr_address,
    input  logic       csr_read,
    output logic [7:0] csr_readdata,
    input  logic       csr_write,
    input  logic [7:0] csr_writedata,
    output logic       irq,
    output logic       tx_line,
    input  logic       rx_line
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // links between the register block and both data paths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    cd_tx_if tx_bus ();
    cd_rx_if rx_bus ();

    cd_csr #(
        .VERSION   (VERSION),
        .DIV_RESET (DIV_RESET)
    ) u_csr (
        .clk           (clk),
        .reset_n       (reset_n),
        .csr_address   (csr_address),
        .csr_read      (csr_read),
        .csr_write     (csr_write),
        .csr_writedata (csr_writedata),
        .csr_readdata  (csr_readdata),
        .irq           (irq),
        .tx            (tx_bus.csr),
        .rx            (rx_bus.csr)
    );

    cd_tx u_tx (
        .clk     (clk),
        .reset_n (reset_n),
        .bus     (tx_bus.tx),
        .tx_line (tx_line)
    );

    cd_rx u_rx (
        .clk     (clk),
        .reset_n (reset_n),
        .bus     (rx_bus.rx),
        .rx_line (rx_line)
    );

endmodule

//--- verification/tb_cd_ctrl.sv
// runs the DUT at divider 8 and idle length 10; the line is either looped back or driven directly
`timescale 1ns/1ps

module tb_cd_ctrl;

    localparam logic [7:0] VERSION = 8'h0f;
    localparam int DIV = 8;
    localparam int IDLE_BITS = 10;
    localparam int NUM_FRAMES = 4;
    localparam int FRAME_MAX = 40;
    localparam int POLL_LIMIT = (FRAME_MAX * 10 + IDLE_BITS + 8) * DIV;
    localparam int WATCHDOG_NS = 2 * NUM_FRAMES * (FRAME_MAX * 10 + IDLE_BITS) * DIV * 100;

    typedef struct packed {
        logic [7:0] len;
        logic       rnd;
        logic [7:0] base;
        logic [7:0] step;
        logic       inv;
        logic [7:0] flags;
    } frame_t;

    logic       clk;
    logic       reset_n;
    logic [4:0] csr_address;
    logic       csr_read;
    logic [7:0] csr_readdata;
    logic       csr_write;
    logic [7:0] csr_writedata;
    logic       irq;
    logic       tx_line;
    logic       rx_line;
    logic       loop_sel;
    logic       inject_line;

    integer     seed;
    int         errors;
    logic [7:0] cur_setting;
    logic [7:0] frame_data [256];
    frame_t     frames [NUM_FRAMES];

    // the receiver hears either its own transmitter or the injected line
    assign rx_line = loop_sel ? tx_line : inject_line;

    cd_ctrl #(
        .VERSION   (VERSION),
        .DIV_RESET (16'(DIV))
    ) UUT (
        .clk           (clk),
        .reset_n       (reset_n),
        .csr_address   (csr_address),
        .csr_read      (csr_read),
        .csr_readdata  (csr_readdata),
        .csr_write     (csr_write),
        .csr_writedata (csr_writedata),
        .irq           (irq),
        .tx_line       (tx_line),
        .rx_line       (rx_line)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register port access
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic write_reg(input cd_pkg::csr_addr_e addr, input logic [7:0] data);
        @(negedge clk);
        csr_address   = addr;
        csr_writedata = data;
        csr_write     = 1'b1;
        @(negedge clk);
        csr_write = 1'b0;
    endtask

    // strobe high gives the read its side effect on the next rising edge
    task automatic read_reg(input cd_pkg::csr_addr_e addr, input logic strobe,
                            output logic [7:0] data);
        @(negedge clk);
        csr_address = addr;
        csr_read    = strobe;
        #20;
        data = csr_readdata;
        @(negedge clk);
        csr_read = 1'b0;
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input cd_pkg::csr_addr_e addr, input logic [7:0] exp);
        logic [7:0] got;
        read_reg(addr, 1'b0, got);
        check_byte(addr.name(), got, exp);
    endtask

    task automatic wait_flag(input int bit_pos, input logic value);
        logic [7:0] flags;
        int         polls;
        polls = 0;
        read_reg(cd_pkg::INT_FLAG, 1'b0, flags);
        while (flags[bit_pos] !== value && polls < POLL_LIMIT) begin
            read_reg(cd_pkg::INT_FLAG, 1'b0, flags);
            polls++;
        end
        if (flags[bit_pos] !== value) begin
            $display("timed out waiting for INT_FLAG bit %0d to become %0b", bit_pos, value);
            errors++;
        end
    endtask

    // a change of the inversion bits glitches the line, so let the receiver settle
    task automatic apply_setting(input logic [7:0] value);
        if (value !== cur_setting) begin
            write_reg(cd_pkg::SETTING, value);
            cur_setting = value;
            repeat (4) @(negedge clk);
            wait_flag(cd_pkg::INT_BUS_IDLE, 1'b1);
            check_addr(cd_pkg::SETTING, value);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // frame helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic fill_frame(input frame_t f);
        for (int i = 0; i < int'(f.len); i++) begin
            if (f.rnd)
                frame_data[i] = 8'($random(seed));
            else
                frame_data[i] = f.base + 8'(i) * f.step;
        end
    endtask

    task automatic send_frame(input int len);
        for (int i = 0; i < len; i++)
            write_reg(cd_pkg::TX, frame_data[i]);
        write_reg(cd_pkg::TX_CTRL, 8'h02);
    endtask

    task automatic check_frame(input int len);
        logic [7:0] data;
        check_addr(cd_pkg::RX_LEN, 8'(len));
        for (int i = 0; i < len; i++) begin
            read_reg(cd_pkg::RX, 1'b1, data);
            check_byte($sformatf("rx_data[%0d]", i), data, frame_data[i]);
        end
    endtask

    task automatic release_page();
        write_reg(cd_pkg::RX_CTRL, 8'h02);
        wait_flag(cd_pkg::INT_RX_PENDING, 1'b0);
    endtask

    // called on a falling edge, holds the level for one bit period
    task automatic inject_bit(input logic b);
        inject_line = b;
        repeat (DIV) @(negedge clk);
    endtask

    task automatic inject_byte(input logic [7:0] data, input logic stop);
        inject_bit(1'b0);
        for (int i = 0; i < 8; i++)
            inject_bit(data[i]);
        inject_bit(stop);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("run stopped by the watchdog after %0d ns with %0d errors", WATCHDOG_NS, errors);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        logic [7:0] data;
        reset_n       = 1'b0;
        csr_address   = 5'd0;
        csr_read      = 1'b0;
        csr_write     = 1'b0;
        csr_writedata = 8'd0;
        loop_sel      = 1'b1;
        inject_line   = 1'b1;
        seed          = 32'h33a9_3714;
        errors        = 0;
        cur_setting   = 8'h00;

        // length, random, base, step, inverted, flags with the page pending
        frames[0] = {8'd1, 1'b0, 8'ha5, 8'h00, 1'b0, 8'h13};
        frames[1] = {8'd5, 1'b0, 8'h11, 8'h22, 1'b0, 8'h13};
        frames[2] = {8'd40, 1'b1, 8'h00, 8'h00, 1'b0, 8'h13};
        frames[3] = {8'd6, 1'b0, 8'hf0, 8'h03, 1'b1, 8'h13};

        repeat (16) @(negedge clk);
        reset_n = 1'b1;

        check_addr(cd_pkg::VERSION, VERSION);
        check_addr(cd_pkg::SETTING, 8'h00);
        check_addr(cd_pkg::IDLE_LEN, 8'd10);
        check_addr(cd_pkg::DIV_L, 8'(DIV));
        check_addr(cd_pkg::DIV_H, 8'h00);
        check_addr(cd_pkg::INT_MASK, 8'h00);
        check_addr(cd_pkg::INT_FLAG, 8'h11);
        check_bit("irq", irq, 1'b0);
        check_bit("tx_line", tx_line, 1'b1);

        // the high byte waits in a backup until the low byte commits both
        write_reg(cd_pkg::DIV_H, 8'h01);
        write_reg(cd_pkg::DIV_L, 8'h23);
        check_addr(cd_pkg::DIV_H, 8'h01);
        check_addr(cd_pkg::DIV_L, 8'h23);
        write_reg(cd_pkg::DIV_L, 8'h10);
        check_addr(cd_pkg::DIV_H, 8'h01);
        check_addr(cd_pkg::DIV_L, 8'h10);
        write_reg(cd_pkg::DIV_H, 8'h00);
        check_addr(cd_pkg::DIV_H, 8'h01);
        write_reg(cd_pkg::DIV_L, 8'(DIV));
        check_addr(cd_pkg::DIV_H, 8'h00);
        check_addr(cd_pkg::DIV_L, 8'(DIV));

        write_reg(cd_pkg::INT_MASK, 8'h02);
        check_addr(cd_pkg::INT_MASK, 8'h02);
        check_bit("irq", irq, 1'b0);

        for (int k = 0; k < NUM_FRAMES; k++) begin
            apply_setting(frames[k].inv ? 8'h42 : 8'h00);
            check_bit("tx_line", tx_line, ~frames[k].inv);
            fill_frame(frames[k]);
            send_frame(int'(frames[k].len));
            wait_flag(cd_pkg::INT_RX_PENDING, 1'b1);
            check_addr(cd_pkg::INT_FLAG, frames[k].flags);
            check_bit("irq", irq, 1'b1);
            check_frame(int'(frames[k].len));
            release_page();
            check_bit("irq", irq, 1'b0);
        end
        apply_setting(8'h00);

        // an empty send must leave the receiver untouched
        write_reg(cd_pkg::TX_CTRL, 8'h02);
        repeat ((IDLE_BITS + 4) * DIV) @(negedge clk);
        check_addr(cd_pkg::INT_FLAG, 8'h11);
        check_bit("irq", irq, 1'b0);

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // back pressure
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        for (int i = 0; i < 3; i++)
            frame_data[i] = 8'h70 + 8'(i);
        send_frame(3);
        wait_flag(cd_pkg::INT_RX_PENDING, 1'b1);
        for (int i = 0; i < 2; i++)
            write_reg(cd_pkg::TX, 8'he0 + 8'(i));
        write_reg(cd_pkg::TX_CTRL, 8'h02);
        wait_flag(cd_pkg::INT_BUS_IDLE, 1'b0);
        wait_flag(cd_pkg::INT_BUS_IDLE, 1'b1);
        check_addr(cd_pkg::INT_FLAG, 8'h1b);
        check_frame(3);
        read_reg(cd_pkg::INT_FLAG, 1'b1, data);
        check_byte("int_flag", data, 8'h1b);
        check_addr(cd_pkg::INT_FLAG, 8'h13);
        release_page();

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // framing error on the injected line
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        @(negedge clk);
        loop_sel = 1'b0;
        inject_byte(8'h5a, 1'b1);
        inject_byte(8'hc3, 1'b0);
        inject_bit(1'b1);
        inject_byte(8'h3c, 1'b1);
        wait_flag(cd_pkg::INT_RX_PENDING, 1'b1);
        check_addr(cd_pkg::INT_FLAG, 8'h17);
        frame_data[0] = 8'h5a;
        frame_data[1] = 8'h3c;
        check_frame(2);
        read_reg(cd_pkg::INT_FLAG, 1'b1, data);
        check_byte("int_flag", data, 8'h17);
        check_addr(cd_pkg::INT_FLAG, 8'h13);
        release_page();
        check_addr(cd_pkg::INT_FLAG, 8'h11);

        $display("checks finished with %0d errors", errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

//--- tb.f
verilog/cd_pkg.sv
verilog/cd_tx_if.sv
verilog/cd_rx_if.sv
verilog/cd_csr.sv
verilog/cd_tx.sv
verilog/cd_rx.sv
verilog/cd_ctrl.sv
verification/tb_cd_ctrl.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing
TOP       ?= tb_cd_ctrl
FILELIST  ?= tb.f

OBJ_DIR = obj_dir
BIN     = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)
